// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_snowball_cache
RTL_TOP   ?= snowball_cache
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/tb_mem_model.sv
module tb_mem_model (
  input  logic                           CPU_CLK,
  input  logic                           RST,
  input  mem_bus_pkg::mem_req_t          mem_req,
  input  logic                           mem_do_act,
  output logic                           mem_ack,
  output logic [mem_bus_pkg::BUS_DW-1:0] mem_rdata,
  input  mem_bus_pkg::mem_req_t          dma_req,
  input  logic                           dma_read,
  input  logic                           dma_wrte,
  output logic                           dma_read_ack,
  output logic                           dma_wrte_ack,
  output logic [mem_bus_pkg::BUS_DW-1:0] dma_data_read
);

  import mem_bus_pkg::*;

  logic [BUS_DW-1:0] mem [1024];     // main memory, word addressed
  logic [BUS_DW-1:0] dma_win [256];  // dma window
  integer            seed;
  int                wait_cnt;
  logic              pending;

  function automatic logic [BUS_DW-1:0] fill_word(input int idx, input logic is_dma);
    logic [BUS_DW-1:0] w;
    if (is_dma)
      w = 32'hD000_0000 ^ (idx * 32'h0010_0007);
    else
      w = 32'h5A00_0000 ^ (idx * 32'h0001_0003);
    return w;
  endfunction

  // ----------------------------------------------------------
  // responder, one access at a time
  // ----------------------------------------------------------
  initial
  begin
    seed          = 78422;
    pending       = 1'b0;
    wait_cnt      = 0;
    mem_ack       = 1'b0;
    dma_read_ack  = 1'b0;
    dma_wrte_ack  = 1'b0;
    mem_rdata     = '0;
    dma_data_read = '0;
    for (int i = 0; i < 1024; i++)
      mem[i] = fill_word(i, 1'b0);
    for (int i = 0; i < 256; i++)
      dma_win[i] = fill_word(i, 1'b1);
    forever
    begin
      @(posedge CPU_CLK);
      #2;
      mem_ack      = 1'b0;   // acks last one cycle
      dma_read_ack = 1'b0;
      dma_wrte_ack = 1'b0;
      if (!RST)
        pending = 1'b0;
      else if (!pending && (mem_do_act || dma_read || dma_wrte))
      begin
        pending  = 1'b1;
        wait_cnt = 1 + ($unsigned($random(seed)) % 4);  // 1 to 4 cycles
      end
      if (pending)
      begin
        wait_cnt = wait_cnt - 1;
        if (wait_cnt == 0)
        begin
          pending = 1'b0;
          if (mem_do_act)
          begin
            if (mem_req.we)
              mem[mem_req.addr[9:0]] = mem_req.wdata;
            mem_rdata = mem[mem_req.addr[9:0]];
            mem_ack   = 1'b1;
          end
          else if (dma_wrte)
          begin
            dma_win[dma_req.addr[7:0]] = dma_req.wdata;
            dma_wrte_ack               = 1'b1;
          end
          else if (dma_read)
          begin
            dma_data_read = dma_win[dma_req.addr[7:0]];
            dma_read_ack  = 1'b1;
          end
        end
      end
    end
  end

endmodule

// File: dv/tb_snowball_cache.sv
module tb_snowball_cache;

  import cache_pkg::*;
  import mem_bus_pkg::*;

  localparam int NUM_ACCESSES   = 59;                 // directed 19, random 40
  localparam int TIMEOUT_CYCLES = 200 * NUM_ACCESSES;

  logic                  CPU_CLK;
  logic                  RST;
  cpu_req_t              cpu_req;
  logic                  cache_inhibit;
  logic                  vmem_act;
  logic                  we_tlb;
  logic [DATA_W-1:0]     cache_datai;
  logic                  cache_busy;
  logic                  mmu_fault;
  mem_req_t              mem_req;
  logic                  mem_do_act;
  logic                  mem_ack;
  logic [BUS_DW-1:0]     mem_rdata;
  mem_req_t              dma_req;
  logic                  dma_read;
  logic                  dma_wrte;
  logic                  dma_read_ack;
  logic                  dma_wrte_ack;
  logic [BUS_DW-1:0]     dma_data_read;

  logic [DATA_W-1:0]     shadow_mem [1024];
  logic [DATA_W-1:0]     shadow_dma [256];
  logic [PAGE_W-1:0]     shadow_page [256];
  logic [VTAG_W-1:0]     shadow_vtag [256];
  integer                seed;
  int                    cycle_cnt;
  int                    err_cnt;

  // handed to the compare process
  event                  rd_done;
  string                 cmp_name;
  logic                  cmp_read;
  logic                  cmp_chk_busy;
  logic [DATA_W-1:0]     cmp_exp_data;
  logic [DATA_W-1:0]     cmp_act_data;
  logic                  cmp_exp_fault;
  logic                  cmp_act_fault;
  logic                  cmp_exp_busy;
  logic                  cmp_act_busy;

  snowball_cache u_dut (
    .CPU_CLK, .RST, .cpu_req, .cache_inhibit, .vmem_act, .we_tlb,
    .cache_datai, .cache_busy, .mmu_fault,
    .mem_req, .mem_do_act, .mem_ack, .mem_rdata,
    .dma_req, .dma_read, .dma_wrte, .dma_read_ack, .dma_wrte_ack, .dma_data_read
  );

  tb_mem_model u_mem (
    .CPU_CLK, .RST, .mem_req, .mem_do_act, .mem_ack, .mem_rdata,
    .dma_req, .dma_read, .dma_wrte, .dma_read_ack, .dma_wrte_ack, .dma_data_read
  );

  initial
  begin
    CPU_CLK = 1'b0;
    forever #10 CPU_CLK = ~CPU_CLK;
  end

  always @(posedge CPU_CLK)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES)
    begin
      $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Something failed");
      $fatal(1);
    end
  end

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  function automatic logic [ADDR_W-1:0] phys_addr(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] p;
    p = addr;
    if (vmem_act)
      p = {shadow_page[addr[15:8]], addr[15:0]};  // page from tlb entry
    return p;
  endfunction

  function automatic logic expected_fault(input logic [ADDR_W-1:0] addr);
    return vmem_act && (shadow_vtag[addr[15:8]] != addr[31:16]);
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] addr);
    logic [ADDR_W-1:0] p;
    logic [DATA_W-1:0] w;
    p = phys_addr(addr);
    if (p[31:30] == 2'b11)
      w = shadow_dma[p[7:0]];
    else
      w = shadow_mem[p[9:0]];
    return w;
  endfunction

  // ----------------------------------------------------------
  // compare tasks and process
  // ----------------------------------------------------------
  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_fault(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("error %s: expected fault %b, actual %b", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("error %s: expected busy %b, actual %b", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic check_strobes(input string name, input logic [2:0] exp,
                               input logic [2:0] act);
    if (act !== exp)
    begin
      err_cnt = err_cnt + 1;
      $display("error %s: expected strobes %b, actual %b", name, exp, act);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  always @(rd_done)
  begin
    check_fault(cmp_name, cmp_exp_fault, cmp_act_fault);
    if (cmp_read && !cmp_exp_fault)
      check_data(cmp_name, cmp_exp_data, cmp_act_data);
    if (cmp_chk_busy)
      check_busy(cmp_name, cmp_exp_busy, cmp_act_busy);
  end

  // ----------------------------------------------------------
  // stimulus tasks
  // ----------------------------------------------------------
  task automatic cpu_access(input string name, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input logic we,
                            input logic fmiss, input logic chk_busy, input logic busy_exp);
    logic              exp_flt;
    logic [DATA_W-1:0] exp_word;
    logic [ADDR_W-1:0] p;
    exp_flt  = expected_fault(addr);
    exp_word = expected_read(addr);
    p        = phys_addr(addr);
    @(posedge CPU_CLK);
    #2;
    cpu_req = '{addr: addr, wdata: wdata, we: we, enable: 1'b1, force_miss: fmiss};
    @(posedge CPU_CLK);
    #2;
    cpu_req.enable = 1'b0;    // one-cycle strobe
    @(posedge CPU_CLK);
    #1;
    cmp_act_busy  = cache_busy;  // hit or fault decided here
    cmp_act_fault = mmu_fault;
    while (cache_busy)
    begin
      @(posedge CPU_CLK);
      #1;
    end
    if (we && !exp_flt)
    begin
      if (p[31:30] == 2'b11)
        shadow_dma[p[7:0]] = wdata;
      else
        shadow_mem[p[9:0]] = wdata;
    end
    cmp_name      = name;
    cmp_read      = !we;
    cmp_chk_busy  = chk_busy;
    cmp_exp_busy  = busy_exp;
    cmp_exp_fault = exp_flt;
    cmp_exp_data  = exp_word;
    cmp_act_data  = cache_datai;
    -> rd_done;
  endtask

  task automatic tlb_write(input logic [7:0] idx, input logic [PAGE_W-1:0] page,
                           input logic [VTAG_W-1:0] vtag);
    @(posedge CPU_CLK);
    #2;
    we_tlb  = 1'b1;
    cpu_req = '{addr: {16'h0, idx, 8'h0}, wdata: {page, vtag}, we: 1'b0,
                enable: 1'b0, force_miss: 1'b0};
    @(posedge CPU_CLK);
    #2;
    we_tlb = 1'b0;
    @(posedge CPU_CLK);
    #1;
    while (cache_busy)
    begin
      @(posedge CPU_CLK);
      #1;
    end
    shadow_page[idx] = page;
    shadow_vtag[idx] = vtag;
  endtask

  // ----------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------
  initial
  begin
    logic [ADDR_W-1:0] rnd_addrs [8];
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d;
    logic              w;
    seed          = 78422;
    cycle_cnt     = 0;
    err_cnt       = 0;
    RST           = 1'b0;
    cpu_req       = '0;
    cache_inhibit = 1'b0;
    vmem_act      = 1'b0;
    we_tlb        = 1'b0;
    for (int i = 0; i < 1024; i++)
      shadow_mem[i] = 32'h5A00_0000 ^ (i * 32'h0001_0003);
    for (int i = 0; i < 256; i++)
    begin
      shadow_dma[i]  = 32'hD000_0000 ^ (i * 32'h0010_0007);
      shadow_page[i] = '0;
      shadow_vtag[i] = '0;
    end
    repeat (16) @(posedge CPU_CLK);
    #2;
    // idle levels while reset is held
    check_busy("reset busy", 1'b0, cache_busy);
    check_fault("reset fault", 1'b0, mmu_fault);
    check_strobes("reset strobes", 3'b000, {mem_do_act, dma_read, dma_wrte});
    RST = 1'b1;

    // plain reads and writes, 0x110 evicts line 0x10
    cpu_access("wr 0x10", 32'h10, 32'h1111_0010, 1'b1, 1'b0, 1'b0, 1'b0);
    cpu_access("wr 0x110", 32'h110, 32'h2222_0110, 1'b1, 1'b0, 1'b0, 1'b0);
    cpu_access("rd miss 0x10", 32'h10, '0, 1'b0, 1'b0, 1'b1, 1'b1);
    cpu_access("rd hit 0x10", 32'h10, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    cpu_access("rd miss 0x110", 32'h110, '0, 1'b0, 1'b0, 1'b1, 1'b1);

    // pair word filled on a miss
    cpu_access("rd miss 0x20", 32'h20, '0, 1'b0, 1'b0, 1'b1, 1'b1);
    cpu_access("rd pair 0x21", 32'h21, '0, 1'b0, 1'b0, 1'b1, 1'b0);

    // write through on a cached line
    cpu_access("wr 0x20", 32'h20, 32'hCAFE_0020, 1'b1, 1'b0, 1'b0, 1'b0);
    cpu_access("rd back 0x20", 32'h20, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    check_data("memory 0x20", shadow_mem[10'h20], u_mem.mem[10'h20]);

    // translation and faults, page in region 11 so the routing shows it
    tlb_write(8'h12, 16'hC003, 16'h00AB);
    #1;
    vmem_act = 1'b1;
    cpu_access("vm rd 0xab1234", 32'h00AB_1234, '0, 1'b0, 1'b0, 1'b0, 1'b0);
    cpu_access("vm wr 0xab1240", 32'h00AB_1240, 32'hBEEF_1240, 1'b1, 1'b0, 1'b0, 1'b0);
    cpu_access("vm rd 0xab1240", 32'h00AB_1240, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    check_data("dma window phys 0xc0031240", shadow_dma[8'h40], u_mem.dma_win[8'h40]);
    cpu_access("fault rd", 32'h00CD_1234, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    cpu_access("fault wr", 32'h00CD_1250, 32'hDEAD_1250, 1'b1, 1'b0, 1'b1, 1'b0);
    check_data("memory after fault", shadow_mem[10'h250], u_mem.mem[10'h250]);
    check_data("dma window after fault", shadow_dma[8'h50], u_mem.dma_win[8'h50]);
    #1;
    vmem_act = 1'b0;

    // dma region and force_miss
    cpu_access("dma rd 5", 32'hC000_0005, '0, 1'b0, 1'b0, 1'b1, 1'b1);
    cpu_access("dma wr 7", 32'hC000_0007, 32'h0D0A_0007, 1'b1, 1'b0, 1'b0, 1'b0);
    cpu_access("dma rd 7", 32'hC000_0007, '0, 1'b0, 1'b0, 1'b1, 1'b0);
    check_data("dma window 7", shadow_dma[8'h07], u_mem.dma_win[8'h07]);
    cpu_access("force miss 5", 32'hC000_0005, '0, 1'b0, 1'b1, 1'b1, 1'b1);

    // random mix over a small address set
    rnd_addrs = '{32'h40, 32'h41, 32'h42, 32'h43, 32'h140, 32'h141,
                  32'hC000_0040, 32'hC000_0041};
    for (int i = 0; i < 40; i++)
    begin
      a = rnd_addrs[3'($unsigned($random(seed)) % 8)];
      d = $random(seed);
      w = ($random(seed) & 1) != 0;
      cpu_access("random", a, d, w, 1'b0, 1'b0, 1'b0);
    end

    repeat (2) @(posedge CPU_CLK);
    if (err_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: flist.f
hdl/cache_pkg.sv
hdl/mem_bus_pkg.sv
hdl/bram_sdp.sv
hdl/cache_lookup.sv
hdl/refill_seq.sv
hdl/snowball_cache.sv
dv/tb_mem_model.sv
dv/tb_snowball_cache.sv

// File: hdl/bram_sdp.sv
module bram_sdp #(
  parameter int WIDTH   = 32,
  parameter int DEPTH_W = 8
) (
  input  logic               CPU_CLK,
  input  logic [DEPTH_W-1:0] raddr,
  input  logic               re,
  output logic [WIDTH-1:0]   rdata,
  input  logic [DEPTH_W-1:0] waddr,
  input  logic               we,
  input  logic [WIDTH-1:0]   wdata
);

  logic [WIDTH-1:0] mem [1 << DEPTH_W];

  // write port
  always_ff @(posedge CPU_CLK)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, output holds while re is low
  always_ff @(posedge CPU_CLK)
  begin
    if (re)
    begin
      rdata <= mem[raddr];  // old data on a same-address write
    end
  end

endmodule

// File: hdl/cache_lookup.sv
module cache_lookup (
  input  logic                                CPU_CLK,
  input  logic                                RST,
  input  cache_pkg::cpu_req_t                 cpu_req,
  input  logic                                cache_inhibit,
  input  logic                                vmem_act,
  input  logic                                we_tlb,
  input  logic [cache_pkg::DATA_W-1:0]        data_rd,
  input  logic [cache_pkg::TAG_W-1:0]         tag_rd,
  input  logic [cache_pkg::DATA_W-1:0]        page_rd,
  input  logic [cache_pkg::DATA_W-1:0]        vtag_rd,
  output logic [cache_pkg::CACHE_IDX_W-1:0]   rd_idx,
  output logic [cache_pkg::TLB_IDX_W-1:0]     tlb_rd_idx,
  output logic                                rd_en,
  output logic [cache_pkg::DATA_W-1:0]        cache_datai,
  output logic                                cache_busy,
  output logic                                mmu_fault,
  output logic                                miss_start,
  output cache_pkg::miss_req_t                miss,
  input  logic                                fill_done,
  input  logic [cache_pkg::DATA_W-1:0]        fill_data,
  input  logic [cache_pkg::CACHE_IDX_W-1:0]   fill_idx
);

  import cache_pkg::*;

  lookup_state_e                 state;
  cpu_req_t                      cur;        // request in the check stage
  logic                          cur_tlb;
  logic                          cur_vmem;
  logic [(1 << CACHE_IDX_W)-1:0] valid;

  logic                          in_check;
  logic                          accept;
  logic                          stage_free;
  logic [PAGE_W-1:0]             phys_page;
  logic [VTAG_W-1:0]             vpage;
  logic [TLB_IDX_W-1:0]          cur_tlb_idx;
  logic [CACHE_IDX_W-1:0]        cur_idx;
  logic                          fault;
  logic                          tag_hit;
  logic                          need_mem;
  logic                          read_hit;

  // ----------------------------------------------------------
  // pre-cycle side, ram read ports
  // ----------------------------------------------------------
  assign in_check   = (state == LK_CHECK);
  assign stage_free = !(in_check && need_mem);
  assign accept     = ((cpu_req.enable && !cache_inhibit) || we_tlb) &&
                      !cache_busy && stage_free;

  assign rd_idx     = cpu_req.addr[CACHE_IDX_W-1:0];
  assign tlb_rd_idx = cpu_req.addr[TLB_IDX_LSB +: TLB_IDX_W];
  assign rd_en      = accept;

  // ----------------------------------------------------------
  // check stage: translation, fault, hit
  // ----------------------------------------------------------
  assign cur_idx     = cur.addr[CACHE_IDX_W-1:0];
  assign cur_tlb_idx = cur.addr[TLB_IDX_LSB +: TLB_IDX_W];
  assign vpage       = cur.addr[PAGE_LSB +: VTAG_W];
  assign phys_page   = cur_vmem ? page_rd[PAGE_W-1:0] : cur.addr[PAGE_LSB +: PAGE_W];

  assign fault    = cur_vmem && !cur_tlb &&
                    (vtag_rd != {{(DATA_W-VTAG_W){1'b0}}, vpage});
  assign tag_hit  = valid[cur_idx] && !cur.force_miss &&
                    (tag_rd == {phys_page, cur_tlb_idx});
  assign need_mem = cur_tlb || (!fault && (cur.we || !tag_hit));  // write-through
  assign read_hit = !need_mem && !fault;

  assign miss_start = in_check && need_mem;

  always_comb
  begin
    miss.addr   = cur_tlb ? cur.addr : {phys_page, cur.addr[PAGE_LSB-1:0]};
    miss.wdata  = cur.wdata;
    miss.we     = cur.we && !cur_tlb;
    miss.tlb_wr = cur_tlb;
  end

  // ----------------------------------------------------------
  // control
  // ----------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= LK_IDLE;
      cache_busy <= 1'b0;
      mmu_fault  <= 1'b0;
      valid      <= '0;   // all lines invalid
    end
    else
    begin
      mmu_fault <= in_check && fault;  // one-cycle pulse
      case (state)
        LK_IDLE:
          if (accept)
            state <= LK_CHECK;
        LK_CHECK:
          if (need_mem)
          begin
            state      <= LK_WAIT;
            cache_busy <= 1'b1;
          end
          else if (!accept)
            state <= LK_IDLE;   // else a back-to-back strobe stays here
        LK_WAIT:
          if (fill_done)
          begin
            state      <= LK_IDLE;
            cache_busy <= 1'b0;
            if (!cur_tlb)
            begin
              valid[fill_idx] <= 1'b1;
              if (!cur.we)
                valid[fill_idx ^ CACHE_IDX_W'(1)] <= 1'b1;  // pair word too
            end
          end
        default:
          state <= LK_IDLE;
      endcase
    end
  end

  // captured request and read data
  always_ff @(posedge CPU_CLK)
  begin
    if (accept)
    begin
      cur      <= cpu_req;
      cur_tlb  <= we_tlb;
      cur_vmem <= vmem_act;
    end
    if (in_check && read_hit && !cur.we)
      cache_datai <= data_rd;
    else if ((state == LK_WAIT) && fill_done && !cur.we && !cur_tlb)
      cache_datai <= fill_data;
  end

  // a miss is only started from an idle memory side
  a_start_not_busy: assert property (@(posedge CPU_CLK) disable iff (!RST)
    miss_start |-> !cache_busy);

  // a faulted access never reaches the memory side
  a_fault_no_start: assert property (@(posedge CPU_CLK) disable iff (!RST)
    miss_start |=> !mmu_fault);

endmodule

// File: hdl/cache_pkg.sv
package cache_pkg;

  // ----------------------------------------------------------
  // cache and tlb geometry
  // ----------------------------------------------------------
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int CACHE_IDX_W = 8;                   // 256 lines of one word
  localparam int TLB_IDX_W   = 8;                   // 256 tlb entries
  localparam int PAGE_W      = 16;                  // physical page
  localparam int VTAG_W      = 16;                  // virtual tag per tlb entry
  localparam int TAG_W       = PAGE_W + TLB_IDX_W;  // page plus tlb index, 24 bits

  // address field positions
  localparam int TLB_IDX_LSB = CACHE_IDX_W;              // bits 15:8
  localparam int PAGE_LSB    = CACHE_IDX_W + TLB_IDX_W;  // bits 31:16

  // ----------------------------------------------------------
  // cpu request, presented in the pre-cycle
  // ----------------------------------------------------------
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic              enable;      // one-cycle strobe
    logic              force_miss;
  } cpu_req_t;

  typedef enum logic [1:0] {
    LK_IDLE,
    LK_CHECK,   // ram data valid, hit decided
    LK_WAIT     // memory side busy
  } lookup_state_e;

  // handed from the lookup stage to the refill sequencer
  typedef struct packed {
    logic [ADDR_W-1:0] addr;    // physical, or raw cpu address for tlb writes
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic              tlb_wr;
  } miss_req_t;

endpackage

// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

  // ----------------------------------------------------------
  // bus constants
  // ----------------------------------------------------------
  localparam int         BUS_AW     = 32;
  localparam int         BUS_DW     = 32;
  localparam logic [1:0] DMA_REGION = 2'b11;               // addr 31:30
  localparam int         PAIR_WORDS = 2;                   // words per read miss
  localparam int         PAIR_CNT_W = $clog2(PAIR_WORDS);

  typedef enum logic {
    RG_MEM,
    RG_DMA
  } region_e;

  // same layout on the memory and the dma port
  typedef struct packed {
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] wdata;
    logic              we;
  } mem_req_t;

  typedef enum logic [1:0] {
    FS_IDLE,
    FS_ACCESS,  // strobe up, waiting for ack
    FS_PAIR,    // gap cycle before the pair word
    FS_DONE
  } fill_state_e;

  function automatic region_e region_of(input logic [BUS_AW-1:0] addr);
    region_e rg;
    rg = (addr[BUS_AW-1 -: 2] == DMA_REGION) ? RG_DMA : RG_MEM;
    return rg;
  endfunction

endpackage

// File: hdl/refill_seq.sv
module refill_seq (
  input  logic                              CPU_CLK,
  input  logic                              RST,
  input  logic                              miss_start,
  input  cache_pkg::miss_req_t              miss,
  output logic                              fill_done,
  output logic [cache_pkg::DATA_W-1:0]      fill_data,
  output logic [cache_pkg::CACHE_IDX_W-1:0] fill_idx,
  output logic                              data_we,
  output logic [cache_pkg::CACHE_IDX_W-1:0] data_waddr,
  output logic [cache_pkg::DATA_W-1:0]      data_wdata,
  output logic [cache_pkg::TAG_W-1:0]       tag_wdata,
  output logic                              tlb_we,
  output logic [cache_pkg::TLB_IDX_W-1:0]   tlb_waddr,
  output logic [cache_pkg::DATA_W-1:0]      page_wdata,
  output logic [cache_pkg::DATA_W-1:0]      vtag_wdata,
  output mem_bus_pkg::mem_req_t             mem_req,
  output logic                              mem_do_act,
  input  logic                              mem_ack,
  input  logic [mem_bus_pkg::BUS_DW-1:0]    mem_rdata,
  output mem_bus_pkg::mem_req_t             dma_req,
  output logic                              dma_read,
  output logic                              dma_wrte,
  input  logic                              dma_read_ack,
  input  logic                              dma_wrte_ack,
  input  logic [mem_bus_pkg::BUS_DW-1:0]    dma_data_read
);

  import cache_pkg::*;
  import mem_bus_pkg::*;

  fill_state_e            state;
  miss_req_t              req;
  logic [BUS_AW-1:0]      cur_addr;    // address of the access in flight
  logic [PAIR_CNT_W-1:0]  word_cnt;
  logic                   launch;
  mem_req_t               launch_req;
  region_e                launch_rg;
  logic                   acked;
  logic [BUS_DW-1:0]      rd_word;

  // ----------------------------------------------------------
  // next access
  // ----------------------------------------------------------
  always_comb
  begin
    launch     = 1'b0;
    launch_req = '{addr: {cur_addr[BUS_AW-1:1], ~cur_addr[0]}, wdata: req.wdata, we: 1'b0};
    if ((state == FS_IDLE) && miss_start && !miss.tlb_wr)
    begin
      launch     = 1'b1;
      launch_req = '{addr: miss.addr, wdata: miss.wdata, we: miss.we};
    end
    else if (state == FS_PAIR)
      launch = 1'b1;   // pair word, always a read
  end

  assign launch_rg = region_of(launch_req.addr);
  assign acked     = (mem_do_act && mem_ack) || (dma_read && dma_read_ack) ||
                     (dma_wrte && dma_wrte_ack);
  assign rd_word   = dma_read ? dma_data_read : mem_rdata;

  // tlb store fields come straight from the latched request
  assign tlb_waddr  = req.addr[TLB_IDX_LSB +: TLB_IDX_W];
  assign page_wdata = {{(DATA_W-PAGE_W){1'b0}}, req.wdata[DATA_W-1 -: PAGE_W]};
  assign vtag_wdata = {{(DATA_W-VTAG_W){1'b0}}, req.wdata[VTAG_W-1:0]};

  // ----------------------------------------------------------
  // sequencer and bus strobes
  // ----------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state      <= FS_IDLE;
      word_cnt   <= '0;
      mem_do_act <= 1'b0;
      dma_read   <= 1'b0;
      dma_wrte   <= 1'b0;
      fill_done  <= 1'b0;
      data_we    <= 1'b0;
      tlb_we     <= 1'b0;
    end
    else
    begin
      fill_done <= 1'b0;
      data_we   <= 1'b0;
      tlb_we    <= 1'b0;
      if (launch)
      begin
        mem_do_act <= (launch_rg == RG_MEM);
        dma_read   <= (launch_rg == RG_DMA) && !launch_req.we;
        dma_wrte   <= (launch_rg == RG_DMA) && launch_req.we;
      end
      else if (acked)
      begin
        mem_do_act <= 1'b0;
        dma_read   <= 1'b0;
        dma_wrte   <= 1'b0;
      end
      case (state)
        FS_IDLE:
          if (miss_start && miss.tlb_wr)
          begin
            tlb_we    <= 1'b1;   // done the cycle after miss_start
            fill_done <= 1'b1;
          end
          else if (miss_start)
          begin
            word_cnt <= '0;
            state    <= FS_ACCESS;
          end
        FS_ACCESS:
          if (acked)
          begin
            data_we <= 1'b1;     // cache line follows every access
            if (!req.we && (word_cnt != PAIR_CNT_W'(PAIR_WORDS - 1)))
            begin
              word_cnt <= word_cnt + PAIR_CNT_W'(1);
              state    <= FS_PAIR;
            end
            else
              state <= FS_DONE;
          end
        FS_PAIR:
          state <= FS_ACCESS;
        FS_DONE:
        begin
          fill_done <= 1'b1;     // last ram write already committed
          state     <= FS_IDLE;
        end
        default:
          state <= FS_IDLE;
      endcase
    end
  end

  // payload
  always_ff @(posedge CPU_CLK)
  begin
    if ((state == FS_IDLE) && miss_start)
    begin
      req      <= miss;
      fill_idx <= miss.addr[CACHE_IDX_W-1:0];
    end
    if (launch)
    begin
      cur_addr <= launch_req.addr;
      mem_req  <= launch_req;
      dma_req  <= launch_req;
    end
    if (acked)
    begin
      data_waddr <= cur_addr[CACHE_IDX_W-1:0];
      tag_wdata  <= cur_addr[BUS_AW-1:CACHE_IDX_W];
      data_wdata <= req.we ? req.wdata : rd_word;
      if (word_cnt == '0)
        fill_data <= rd_word;  // requested word
    end
  end

  // only one bus is driven at a time
  a_one_port: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $onehot0({mem_do_act, dma_read, dma_wrte}));

endmodule

// File: hdl/snowball_cache.sv
module snowball_cache (
  input  logic                           CPU_CLK,
  input  logic                           RST,
  // cpu side
  input  cache_pkg::cpu_req_t            cpu_req,
  input  logic                           cache_inhibit,
  input  logic                           vmem_act,
  input  logic                           we_tlb,
  output logic [cache_pkg::DATA_W-1:0]   cache_datai,
  output logic                           cache_busy,
  output logic                           mmu_fault,
  // main memory
  output mem_bus_pkg::mem_req_t          mem_req,
  output logic                           mem_do_act,
  input  logic                           mem_ack,
  input  logic [mem_bus_pkg::BUS_DW-1:0] mem_rdata,
  // dma window
  output mem_bus_pkg::mem_req_t          dma_req,
  output logic                           dma_read,
  output logic                           dma_wrte,
  input  logic                           dma_read_ack,
  input  logic                           dma_wrte_ack,
  input  logic [mem_bus_pkg::BUS_DW-1:0] dma_data_read
);

  import cache_pkg::*;

  logic [DATA_W-1:0]      data_rd;
  logic [TAG_W-1:0]       tag_rd;
  logic [DATA_W-1:0]      page_rd;
  logic [DATA_W-1:0]      vtag_rd;
  logic [CACHE_IDX_W-1:0] rd_idx;
  logic [TLB_IDX_W-1:0]   tlb_rd_idx;
  logic                   rd_en;
  logic                   miss_start;
  miss_req_t              miss;
  logic                   fill_done;
  logic [DATA_W-1:0]      fill_data;
  logic [CACHE_IDX_W-1:0] fill_idx;
  logic                   data_we;
  logic [CACHE_IDX_W-1:0] data_waddr;
  logic [DATA_W-1:0]      data_wdata;
  logic [TAG_W-1:0]       tag_wdata;
  logic                   tlb_we;
  logic [TLB_IDX_W-1:0]   tlb_waddr;
  logic [DATA_W-1:0]      page_wdata;
  logic [DATA_W-1:0]      vtag_wdata;

  cache_lookup u_lookup (
    .CPU_CLK, .RST, .cpu_req, .cache_inhibit, .vmem_act, .we_tlb,
    .data_rd, .tag_rd, .page_rd, .vtag_rd, .rd_idx, .tlb_rd_idx, .rd_en,
    .cache_datai, .cache_busy, .mmu_fault, .miss_start, .miss,
    .fill_done, .fill_data, .fill_idx
  );

  refill_seq u_refill (
    .CPU_CLK, .RST, .miss_start, .miss, .fill_done, .fill_data, .fill_idx,
    .data_we, .data_waddr, .data_wdata, .tag_wdata,
    .tlb_we, .tlb_waddr, .page_wdata, .vtag_wdata,
    .mem_req, .mem_do_act, .mem_ack, .mem_rdata,
    .dma_req, .dma_read, .dma_wrte, .dma_read_ack, .dma_wrte_ack, .dma_data_read
  );

  // ----------------------------------------------------------
  // cache and tlb stores
  // ----------------------------------------------------------
  bram_sdp #(.WIDTH(DATA_W), .DEPTH_W(CACHE_IDX_W)) u_data_ram (
    .CPU_CLK, .raddr(rd_idx), .re(rd_en), .rdata(data_rd),
    .waddr(data_waddr), .we(data_we), .wdata(data_wdata)
  );

  bram_sdp #(.WIDTH(TAG_W), .DEPTH_W(CACHE_IDX_W)) u_tag_ram (
    .CPU_CLK, .raddr(rd_idx), .re(rd_en), .rdata(tag_rd),
    .waddr(data_waddr), .we(data_we), .wdata(tag_wdata)
  );

  bram_sdp #(.WIDTH(DATA_W), .DEPTH_W(TLB_IDX_W)) u_tlb_page (
    .CPU_CLK, .raddr(tlb_rd_idx), .re(rd_en), .rdata(page_rd),
    .waddr(tlb_waddr), .we(tlb_we), .wdata(page_wdata)
  );

  bram_sdp #(.WIDTH(DATA_W), .DEPTH_W(TLB_IDX_W)) u_tlb_vtag (
    .CPU_CLK, .raddr(tlb_rd_idx), .re(rd_en), .rdata(vtag_rd),
    .waddr(tlb_waddr), .we(tlb_we), .wdata(vtag_wdata)
  );

endmodule
